// ==== rtl/dfe_reg_defs.svh ====
// widths are fixed by the PMA, so none of these are meant to be overridden
// field positions cover only control, tap 1, tap 2 and step

`ifndef DFE_REG_DEFS_SVH
`define DFE_REG_DEFS_SVH

// widths
`define DFE_UIF_ADDR_W 6
`define DFE_PHY_ADDR_W 12
`define DFE_DATA_W     16
`define DFE_STEP_W     3
`define DFE_OP_W       3

// logical offsets seen by the user
`define DFE_OFF_CTRL   6'd0
`define DFE_OFF_TAP1   6'd1
`define DFE_OFF_TAP2   6'd2
`define DFE_OFF_STEP   6'd7
`define DFE_OFF_DFE12  6'd12
`define DFE_OFF_DFE13  6'd13

// physical PMA register addresses
`define DFE_PHY_DFE11  12'h00b
`define DFE_PHY_DFE12  12'h00c
`define DFE_PHY_DFE13  12'h00d

// user modes and basic block opcodes
`define DFE_MODE_RD    3'd0
`define DFE_MODE_WR    3'd1
`define DFE_OP_RD      3'd0
`define DFE_OP_WR      3'd1

// ------------------------------
// user word bit positions
`define DFE_U_ADAPT    0   // control
`define DFE_U_PDB      1
`define DFE_U_T1_HI    3   // tap 1
`define DFE_U_T1_LO    0
`define DFE_U_T2_HI    2   // tap 2 coefficient
`define DFE_U_T2_LO    0
`define DFE_U_T2INV    3
`define DFE_U_PIEN     0   // step
`define DFE_U_S0D      1
`define DFE_U_S90D     2
`define DFE_U_STEP_HI  6
`define DFE_U_STEP_LO  3

// ------------------------------
// physical register bit positions
`define DFE_P_T1_HI    3   // dfe11
`define DFE_P_T1_LO    0
`define DFE_P_T2_HI    6
`define DFE_P_T2_LO    4
`define DFE_P_ADAPT    15
`define DFE_P_PDB      7   // dfe12
`define DFE_P_BYPASS   0   // dfe13
`define DFE_P_PIEN     1
`define DFE_P_S0D      2
`define DFE_P_S90D     3
`define DFE_P_STEP_HI  8
`define DFE_P_STEP_LO  5
`define DFE_P_T2INV    9

`endif

// ==== rtl/dfe_reg_pkg.sv ====
// shared types for the DFE register access unit
// widths come from dfe_reg_defs.svh

`default_nettype none

`include "dfe_reg_defs.svh"

package dfe_reg_pkg;

    typedef logic [`DFE_UIF_ADDR_W-1:0] uif_addr_t;   // logical offset
    typedef logic [`DFE_PHY_ADDR_W-1:0] phy_addr_t;   // pma register address
    typedef logic [`DFE_DATA_W-1:0]     reg_data_t;
    typedef logic [`DFE_STEP_W-1:0]     step_t;       // one-hot, bit 0 is last cycle
    typedef logic [`DFE_OP_W-1:0]       op_t;         // opcode or user mode

    // access sequencer states
    typedef enum logic [1:0] {
        st_idle,
        st_rmw_rd,     // read half of a read-modify-write
        st_rmw_wr,     // write half
        st_rd          // plain read for a user read
    } access_state_t;

endpackage

`default_nettype wire

// ==== rtl/dfe_access_fsm.sv ====
// one access at a time, the basic block may hold off ctrl_done for as long as it likes
// ctrl_chan_err is only looked at together with ctrl_done and aborts the access

`default_nettype none

`include "dfe_reg_defs.svh"

module dfe_access_fsm (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      uif_go,
    input  wire dfe_reg_pkg::op_t    uif_mode,
    input  wire                      addr_legal,
    input  wire dfe_reg_pkg::step_t  first_step,
    input  wire                      ctrl_done,
    input  wire                      ctrl_chan_err,
    output logic                     uif_busy,
    output logic                     uif_addr_err,
    output logic                     ctrl_go,
    output logic                     ctrl_lock,
    output dfe_reg_pkg::op_t         ctrl_opcode,
    output dfe_reg_pkg::step_t       step,
    output logic                     rd_clear,
    output logic                     rd_capture
);

    dfe_reg_pkg::access_state_t state;

    logic is_wr;
    logic accept;       // go seen in idle with a legal address
    logic abort;
    logic step_done;    // done that ends one physical pair or read
    logic last;
    logic go_ff1;       // first cycle after accept
    logic go_ff2;       // follow-on cycles

    assign is_wr     = (uif_mode == `DFE_MODE_WR);
    assign accept    = (state == dfe_reg_pkg::st_idle) && uif_go && addr_legal;
    assign abort     = ctrl_done && ctrl_chan_err;
    assign last      = step[0];
    assign step_done = ctrl_done && !ctrl_chan_err &&
                       ((state == dfe_reg_pkg::st_rmw_wr) || (state == dfe_reg_pkg::st_rd));

    assign rd_clear   = accept && !is_wr;
    assign rd_capture = (state == dfe_reg_pkg::st_rd) && ctrl_done && !ctrl_chan_err;

    // ------------------------------
    // state machine
    always_ff @(posedge clk) begin
        if (reset || abort) begin
            state <= dfe_reg_pkg::st_idle;
        end else begin
            case (state)
                dfe_reg_pkg::st_idle: begin
                    if (accept && is_wr) begin
                        state <= dfe_reg_pkg::st_rmw_rd;
                    end else if (accept) begin
                        state <= dfe_reg_pkg::st_rd;
                    end
                end
                dfe_reg_pkg::st_rmw_rd: begin
                    if (ctrl_done) state <= dfe_reg_pkg::st_rmw_wr;
                end
                dfe_reg_pkg::st_rmw_wr: begin
                    if (ctrl_done && last) begin
                        state <= dfe_reg_pkg::st_idle;
                    end else if (ctrl_done) begin
                        state <= dfe_reg_pkg::st_rmw_rd;   // next pair
                    end
                end
                dfe_reg_pkg::st_rd: begin
                    if (ctrl_done && last) state <= dfe_reg_pkg::st_idle;
                end
                default: state <= dfe_reg_pkg::st_idle;
            endcase
        end
    end

    // one-hot step, shifted after each pair or read
    always_ff @(posedge clk) begin
        if (reset) begin
            step <= '0;
        end else if (accept) begin
            step <= first_step;
        end else if (step_done) begin
            step <= step >> 1;
        end
    end

    // ------------------------------
    // user and basic block outputs
    always_ff @(posedge clk) begin
        if (reset) begin
            uif_busy     <= 1'b0;
            uif_addr_err <= 1'b0;
            go_ff1       <= 1'b0;
            go_ff2       <= 1'b0;
            ctrl_go      <= 1'b0;
            ctrl_lock    <= 1'b0;
            ctrl_opcode  <= `DFE_OP_RD;
        end else begin
            if (accept) begin
                uif_busy <= 1'b1;
            end else if (abort || (step_done && last)) begin
                uif_busy <= 1'b0;
            end

            if ((state == dfe_reg_pkg::st_idle) && uif_go) begin
                uif_addr_err <= !addr_legal;
            end

            go_ff1 <= accept;
            go_ff2 <= ctrl_done && !ctrl_chan_err &&
                      ((state == dfe_reg_pkg::st_rmw_rd) || !last);  // not after final done
            ctrl_go <= go_ff1 || go_ff2;   // address and data settle first

            ctrl_lock <= (state == dfe_reg_pkg::st_rmw_rd) ||
                         (((state == dfe_reg_pkg::st_rmw_wr) ||
                           (state == dfe_reg_pkg::st_rd)) && !last);

            ctrl_opcode <= (state == dfe_reg_pkg::st_rmw_wr) ? `DFE_OP_WR : `DFE_OP_RD;
        end
    end

    // step must stay a single bit for the whole access
    a_step_onehot: assert property (@(posedge clk) disable iff (reset)
        uif_busy |-> $onehot(step));

    a_no_go_idle: assert property (@(posedge clk) disable iff (reset)
        ctrl_go |-> (state != dfe_reg_pkg::st_idle));

endmodule

`default_nettype wire

// ==== rtl/dfe_field_map.sv ====
// ctrl_wdata is re-registered every cycle from ctrl_rdata, so the basic block
// must hold ctrl_rdata after the read done until the write ctrl_go

`default_nettype none

`include "dfe_reg_defs.svh"

module dfe_field_map (
    input  wire                         clk,
    input  wire dfe_reg_pkg::uif_addr_t uif_addr,
    input  wire dfe_reg_pkg::op_t       uif_mode,
    input  wire dfe_reg_pkg::reg_data_t uif_wdata,
    input  wire dfe_reg_pkg::step_t     step,
    input  wire dfe_reg_pkg::reg_data_t ctrl_rdata,
    output logic                        addr_legal,
    output dfe_reg_pkg::step_t          first_step,
    output dfe_reg_pkg::phy_addr_t      ctrl_addr,
    output dfe_reg_pkg::reg_data_t      ctrl_wdata,
    output dfe_reg_pkg::reg_data_t      rd_field
);

    logic                   is_wr;
    logic                   off_legal;
    logic                   mode_ok;
    dfe_reg_pkg::phy_addr_t addr_nxt;
    dfe_reg_pkg::reg_data_t wdata_nxt;

    assign is_wr      = (uif_mode == `DFE_MODE_WR);
    assign mode_ok    = (uif_mode == `DFE_MODE_RD) || is_wr;
    assign addr_legal = off_legal && mode_ok;

    // ------------------------------
    // offset decode, number of physical cycles
    always_comb begin
        off_legal  = 1'b1;
        first_step = '0;
        case (uif_addr)
            `DFE_OFF_CTRL:  first_step = is_wr ? 3'b100 : 3'b010;  // bypass leg on writes
            `DFE_OFF_TAP2:  first_step = 3'b010;
            `DFE_OFF_TAP1,
            `DFE_OFF_STEP,
            `DFE_OFF_DFE12,
            `DFE_OFF_DFE13: first_step = 3'b001;
            default:        off_legal  = 1'b0;
        endcase
    end

    // ------------------------------
    // physical address, write merge and read extract per step
    always_comb begin
        addr_nxt  = `DFE_PHY_DFE11;
        wdata_nxt = ctrl_rdata;       // untouched bits pass back unchanged
        rd_field  = '0;
        if (step[2]) begin
            addr_nxt                 = `DFE_PHY_DFE13;
            wdata_nxt[`DFE_P_BYPASS] = ~uif_wdata[`DFE_U_ADAPT];
        end else if (step[1]) begin
            case (uif_addr)          // dfe11 leg
                `DFE_OFF_CTRL: begin
                    wdata_nxt[`DFE_P_ADAPT] = uif_wdata[`DFE_U_ADAPT];
                    rd_field[`DFE_U_ADAPT]  = ctrl_rdata[`DFE_P_ADAPT];
                end
                `DFE_OFF_TAP2: begin
                    wdata_nxt[`DFE_P_T2_HI:`DFE_P_T2_LO] = uif_wdata[`DFE_U_T2_HI:`DFE_U_T2_LO];
                    rd_field[`DFE_U_T2_HI:`DFE_U_T2_LO]  = ctrl_rdata[`DFE_P_T2_HI:`DFE_P_T2_LO];
                end
                default: ;
            endcase
        end else begin
            case (uif_addr)          // last leg
                `DFE_OFF_CTRL: begin
                    addr_nxt              = `DFE_PHY_DFE12;
                    wdata_nxt[`DFE_P_PDB] = uif_wdata[`DFE_U_PDB];
                    rd_field[`DFE_U_PDB]  = ctrl_rdata[`DFE_P_PDB];
                end
                `DFE_OFF_TAP1: begin
                    wdata_nxt[`DFE_P_T1_HI:`DFE_P_T1_LO] = uif_wdata[`DFE_U_T1_HI:`DFE_U_T1_LO];
                    rd_field[`DFE_U_T1_HI:`DFE_U_T1_LO]  = ctrl_rdata[`DFE_P_T1_HI:`DFE_P_T1_LO];
                end
                `DFE_OFF_TAP2: begin
                    addr_nxt                = `DFE_PHY_DFE13;   // polarity
                    wdata_nxt[`DFE_P_T2INV] = uif_wdata[`DFE_U_T2INV];
                    rd_field[`DFE_U_T2INV]  = ctrl_rdata[`DFE_P_T2INV];
                end
                `DFE_OFF_STEP: begin
                    addr_nxt               = `DFE_PHY_DFE13;
                    wdata_nxt[`DFE_P_PIEN] = uif_wdata[`DFE_U_PIEN];
                    wdata_nxt[`DFE_P_S0D]  = uif_wdata[`DFE_U_S0D];
                    wdata_nxt[`DFE_P_S90D] = uif_wdata[`DFE_U_S90D];
                    wdata_nxt[`DFE_P_STEP_HI:`DFE_P_STEP_LO] =
                        uif_wdata[`DFE_U_STEP_HI:`DFE_U_STEP_LO];
                    rd_field[`DFE_U_PIEN]  = ctrl_rdata[`DFE_P_PIEN];
                    rd_field[`DFE_U_S0D]   = ctrl_rdata[`DFE_P_S0D];
                    rd_field[`DFE_U_S90D]  = ctrl_rdata[`DFE_P_S90D];
                    rd_field[`DFE_U_STEP_HI:`DFE_U_STEP_LO] =
                        ctrl_rdata[`DFE_P_STEP_HI:`DFE_P_STEP_LO];
                end
                `DFE_OFF_DFE12: begin
                    addr_nxt  = `DFE_PHY_DFE12;  // raw pass-through
                    wdata_nxt = uif_wdata;
                    rd_field  = ctrl_rdata;
                end
                `DFE_OFF_DFE13: begin
                    addr_nxt  = `DFE_PHY_DFE13;
                    wdata_nxt = uif_wdata;
                    rd_field  = ctrl_rdata;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        ctrl_addr  <= addr_nxt;
        ctrl_wdata <= wdata_nxt;
    end

    // once at most one-hot, the sequencer keeps it that way on every edge
    a_step_onehot0: assert property (@(posedge clk) $onehot0(step) |=> $onehot0(step));

endmodule

`default_nettype wire

// ==== rtl/dfe_rdata_collect.sv ====
// read word is only meaningful once uif_busy has fallen after a read

`default_nettype none

module dfe_rdata_collect (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         rd_clear,
    input  wire                         rd_capture,
    input  wire dfe_reg_pkg::reg_data_t rd_field,
    output dfe_reg_pkg::reg_data_t      uif_rdata
);

    // fields of separate physical reads never overlap, so OR merges them
    always_ff @(posedge clk) begin
        if (reset) begin
            uif_rdata <= '0;
        end else if (rd_clear) begin
            uif_rdata <= '0;                     // new user read
        end else if (rd_capture) begin
            uif_rdata <= uif_rdata | rd_field;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dfe_reg_top.sv ====
// uif_addr, uif_mode and uif_wdata must stay stable while uif_busy is high
// ctrl_rdata must hold its value after ctrl_done until the next ctrl_go

`default_nettype none

module dfe_reg_top (
    input  wire                         clk,
    input  wire                         reset,

    // user side
    input  wire                         uif_go,
    input  wire dfe_reg_pkg::op_t       uif_mode,
    input  wire dfe_reg_pkg::uif_addr_t uif_addr,
    input  wire dfe_reg_pkg::reg_data_t uif_wdata,
    output wire dfe_reg_pkg::reg_data_t uif_rdata,
    output wire                         uif_busy,
    output wire                         uif_addr_err,

    // basic block side
    output wire                         ctrl_go,
    output wire dfe_reg_pkg::op_t       ctrl_opcode,
    output wire                         ctrl_lock,
    output wire dfe_reg_pkg::phy_addr_t ctrl_addr,
    output wire dfe_reg_pkg::reg_data_t ctrl_wdata,
    input  wire                         ctrl_done,
    input  wire dfe_reg_pkg::reg_data_t ctrl_rdata,
    input  wire                         ctrl_chan_err
);

    wire                         addr_legal;
    wire dfe_reg_pkg::step_t     first_step;
    wire dfe_reg_pkg::step_t     step;
    wire                         rd_clear;
    wire                         rd_capture;
    wire dfe_reg_pkg::reg_data_t rd_field;

    dfe_access_fsm i_access_fsm (
        .clk           (clk),
        .reset         (reset),
        .uif_go        (uif_go),
        .uif_mode      (uif_mode),
        .addr_legal    (addr_legal),
        .first_step    (first_step),
        .ctrl_done     (ctrl_done),
        .ctrl_chan_err (ctrl_chan_err),
        .uif_busy      (uif_busy),
        .uif_addr_err  (uif_addr_err),
        .ctrl_go       (ctrl_go),
        .ctrl_lock     (ctrl_lock),
        .ctrl_opcode   (ctrl_opcode),
        .step          (step),
        .rd_clear      (rd_clear),
        .rd_capture    (rd_capture)
    );

    dfe_field_map i_field_map (
        .clk        (clk),
        .uif_addr   (uif_addr),
        .uif_mode   (uif_mode),
        .uif_wdata  (uif_wdata),
        .step       (step),
        .ctrl_rdata (ctrl_rdata),
        .addr_legal (addr_legal),
        .first_step (first_step),
        .ctrl_addr  (ctrl_addr),
        .ctrl_wdata (ctrl_wdata),
        .rd_field   (rd_field)
    );

    dfe_rdata_collect i_rdata_collect (
        .clk        (clk),
        .reset      (reset),
        .rd_clear   (rd_clear),
        .rd_capture (rd_capture),
        .rd_field   (rd_field),
        .uif_rdata  (uif_rdata)
    );

endmodule

`default_nettype wire

// ==== testbench/phy_reg_model.sv ====
// answers each ctrl_go after 1 to 4 cycles, ctrl_rdata holds until the next read done
// ctrl_chan_err pulses with ctrl_done while err_inject is high

`default_nettype none

`include "dfe_reg_defs.svh"

module phy_reg_model (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        ctrl_go,
    input  wire [`DFE_OP_W-1:0]        ctrl_opcode,
    input  wire [`DFE_PHY_ADDR_W-1:0]  ctrl_addr,
    input  wire [`DFE_DATA_W-1:0]      ctrl_wdata,
    input  wire                        err_inject,
    output logic                       ctrl_done,
    output logic [`DFE_DATA_W-1:0]     ctrl_rdata,
    output logic                       ctrl_chan_err
);

    logic [`DFE_DATA_W-1:0]     regs [0:4095];     // whole pma address space
    logic [`DFE_PHY_ADDR_W-1:0] addr_log [0:63];   // ring of go addresses
    int unsigned                go_count;
    logic [31:0]                rnd;
    logic                       pending;
    logic [2:0]                 wait_cnt;
    logic [`DFE_PHY_ADDR_W-1:0] cur_addr;
    logic                       cur_wr;
    logic [`DFE_DATA_W-1:0]     cur_wdata;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // preload differs for every address
    function automatic logic [`DFE_DATA_W-1:0] fill_value(input logic [11:0] a);
        return {a[3:0], a} ^ 16'h6c93;
    endfunction

    always @(posedge clk) begin
        ctrl_done     <= 1'b0;
        ctrl_chan_err <= 1'b0;
        if (reset) begin
            pending    <= 1'b0;
            wait_cnt   <= 3'd0;
            go_count   <= 0;
            rnd        <= 32'hba65_b944;
            ctrl_rdata <= '0;
            for (int a = 0; a < 4096; a++) begin
                regs[a[11:0]] <= fill_value(a[11:0]);
            end
        end else if (ctrl_go) begin
            pending   <= 1'b1;
            wait_cnt  <= {1'b0, rnd[1:0]} + 3'd1;   // 1 to 4 cycles
            rnd       <= xorshift32(rnd);
            cur_addr  <= ctrl_addr;
            cur_wr    <= (ctrl_opcode == `DFE_OP_WR);
            cur_wdata <= ctrl_wdata;
            addr_log[go_count[5:0]] <= ctrl_addr;
            go_count  <= go_count + 1;
        end else if (pending) begin
            if (wait_cnt == 3'd1) begin
                pending       <= 1'b0;
                ctrl_done     <= 1'b1;
                ctrl_chan_err <= err_inject;
                if (cur_wr) begin
                    regs[cur_addr] <= cur_wdata;
                end else begin
                    ctrl_rdata <= regs[cur_addr];
                end
            end else begin
                wait_cnt <= wait_cnt - 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_dfe_reg.sv ====
// directed tests of dfe_reg_top against phy_reg_model
// inputs change on the rising edge, outputs are sampled on the falling edge

`default_nettype none

`include "dfe_reg_defs.svh"

module tb_dfe_reg;

    logic                        clk = 1'b0;
    logic                        reset;
    logic                        uif_go;
    logic [`DFE_OP_W-1:0]        uif_mode;
    logic [`DFE_UIF_ADDR_W-1:0]  uif_addr;
    logic [`DFE_DATA_W-1:0]      uif_wdata;
    logic [`DFE_DATA_W-1:0]      uif_rdata;
    logic                        uif_busy;
    logic                        uif_addr_err;
    logic                        ctrl_go;
    logic [`DFE_OP_W-1:0]        ctrl_opcode;
    logic                        ctrl_lock;
    logic [`DFE_PHY_ADDR_W-1:0]  ctrl_addr;
    logic [`DFE_DATA_W-1:0]      ctrl_wdata;
    logic                        ctrl_done;
    logic [`DFE_DATA_W-1:0]      ctrl_rdata;
    logic                        ctrl_chan_err;
    logic                        err_inject;
    int                          errors = 0;
    int                          checks = 0;
    int                          go_seen;     // ctrl_go pulses in the last access
    int                          go_locked;   // of those, with ctrl_lock high
    logic                        last_lock;

    always #10 clk = ~clk;

    dfe_reg_top i_dut (
        .clk (clk), .reset (reset),
        .uif_go (uif_go), .uif_mode (uif_mode), .uif_addr (uif_addr),
        .uif_wdata (uif_wdata), .uif_rdata (uif_rdata),
        .uif_busy (uif_busy), .uif_addr_err (uif_addr_err),
        .ctrl_go (ctrl_go), .ctrl_opcode (ctrl_opcode), .ctrl_lock (ctrl_lock),
        .ctrl_addr (ctrl_addr), .ctrl_wdata (ctrl_wdata),
        .ctrl_done (ctrl_done), .ctrl_rdata (ctrl_rdata), .ctrl_chan_err (ctrl_chan_err)
    );

    phy_reg_model i_phy (
        .clk (clk), .reset (reset),
        .ctrl_go (ctrl_go), .ctrl_opcode (ctrl_opcode), .ctrl_addr (ctrl_addr),
        .ctrl_wdata (ctrl_wdata), .err_inject (err_inject),
        .ctrl_done (ctrl_done), .ctrl_rdata (ctrl_rdata), .ctrl_chan_err (ctrl_chan_err)
    );

    // ------------------------------
    // reference model from the field table
    function automatic logic [15:0] phy_after_write(input logic [11:0] paddr,
                                                    input logic [5:0] uaddr,
                                                    input logic [15:0] old,
                                                    input logic [15:0] w);
        logic [15:0] v;
        v = old;
        if (paddr == `DFE_PHY_DFE11) begin
            if (uaddr == `DFE_OFF_CTRL) v[15] = w[0];     // adapt
            if (uaddr == `DFE_OFF_TAP1) v[3:0] = w[3:0];
            if (uaddr == `DFE_OFF_TAP2) v[6:4] = w[2:0];
        end else if (paddr == `DFE_PHY_DFE12) begin
            if (uaddr == `DFE_OFF_CTRL) v[7] = w[1];      // power-down
            if (uaddr == `DFE_OFF_DFE12) v = w;
        end else begin
            if (uaddr == `DFE_OFF_CTRL) v[0] = ~w[0];     // bypass
            if (uaddr == `DFE_OFF_TAP2) v[9] = w[3];
            if (uaddr == `DFE_OFF_STEP) begin
                v[3:1] = w[2:0];
                v[8:5] = w[6:3];
            end
            if (uaddr == `DFE_OFF_DFE13) v = w;
        end
        return v;
    endfunction

    task automatic check(input string what, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int base_err);
        $display("test %s finished with %0d mismatches", name, errors - base_err);
    endtask

    // one user access, returns once busy has fallen
    task automatic run_access(input logic [2:0] mode, input logic [5:0] addr,
                              input logic [15:0] wdata, output logic [15:0] rdata);
        int n;
        go_seen   = 0;
        go_locked = 0;
        last_lock = 1'b0;
        @(posedge clk);
        uif_mode  <= mode;
        uif_addr  <= addr;
        uif_wdata <= wdata;
        uif_go    <= 1'b1;
        @(posedge clk);
        uif_go    <= 1'b0;
        @(negedge clk);
        check("busy after go", {15'b0, uif_busy}, 16'd1);
        n = 0;
        while (uif_busy && n < 200) begin
            @(negedge clk);
            n++;
            if (ctrl_go) begin
                go_seen++;
                last_lock = ctrl_lock;
                if (ctrl_lock) go_locked++;
            end
        end
        if (uif_busy) begin
            errors++;
            $display("uif_busy never fell for offset %0d, time %0t", addr, $time);
        end
        rdata = uif_rdata;
    endtask

    // lock stays high through the access and drops on its last physical cycle
    task automatic verify_lock();
        check("ctrl_lock on earlier cycles", 16'(go_locked), 16'(go_seen - 1));
        check("ctrl_lock on last cycle", {15'b0, last_lock}, 16'd0);
    endtask

    task automatic write_and_compare(input logic [5:0] uaddr, input logic [15:0] w);
        logic [15:0] old11;
        logic [15:0] old12;
        logic [15:0] old13;
        logic [15:0] rd;
        old11 = i_phy.regs[`DFE_PHY_DFE11];
        old12 = i_phy.regs[`DFE_PHY_DFE12];
        old13 = i_phy.regs[`DFE_PHY_DFE13];
        run_access(`DFE_MODE_WR, uaddr, w, rd);
        verify_lock();
        check("dfe11 after write", i_phy.regs[`DFE_PHY_DFE11],
              phy_after_write(`DFE_PHY_DFE11, uaddr, old11, w));
        check("dfe12 after write", i_phy.regs[`DFE_PHY_DFE12],
              phy_after_write(`DFE_PHY_DFE12, uaddr, old12, w));
        check("dfe13 after write", i_phy.regs[`DFE_PHY_DFE13],
              phy_after_write(`DFE_PHY_DFE13, uaddr, old13, w));
    endtask

    task automatic read_and_compare(input logic [5:0] uaddr, input logic [15:0] exp);
        logic [15:0] rd;
        run_access(`DFE_MODE_RD, uaddr, 16'h0000, rd);
        verify_lock();
        check("read word", rd, exp);
    endtask

    // ------------------------------
    // directed tests
    task automatic tap1_access();
        int base_err;
        base_err = errors;
        write_and_compare(`DFE_OFF_TAP1, 16'hbeea);
        read_and_compare(`DFE_OFF_TAP1, 16'hbeea & 16'h000f);   // bits 3..0 only
        report_test("tap 1", base_err);
    endtask

    task automatic tap2_step_access();
        int base_err;
        base_err = errors;
        write_and_compare(`DFE_OFF_TAP2, 16'hfffd);
        read_and_compare(`DFE_OFF_TAP2, 16'h000d);     // coefficient 5 with polarity
        write_and_compare(`DFE_OFF_STEP, 16'h005b);
        read_and_compare(`DFE_OFF_STEP, 16'h005b);
        write_and_compare(`DFE_OFF_TAP2, 16'h0002);
        read_and_compare(`DFE_OFF_TAP2, 16'h0002);
        report_test("tap 2 and step", base_err);
    endtask

    task automatic ctrl_write_order();
        int          base_err;
        int unsigned base_go;
        logic [5:0]  idx;
        logic [11:0] exp_addr;
        base_err = errors;
        base_go  = i_phy.go_count;
        write_and_compare(`DFE_OFF_CTRL, 16'h0001);
        check("ctrl go count", 16'(i_phy.go_count - base_go), 16'd6);
        for (int i = 0; i < 6; i++) begin
            idx = 6'(base_go + i);
            case (i / 2)   // read and write per register
                0:       exp_addr = `DFE_PHY_DFE13;
                1:       exp_addr = `DFE_PHY_DFE11;
                default: exp_addr = `DFE_PHY_DFE12;
            endcase
            check("ctrl access order", {4'b0, i_phy.addr_log[idx]}, {4'b0, exp_addr});
        end
        read_and_compare(`DFE_OFF_CTRL, 16'h0001);
        write_and_compare(`DFE_OFF_CTRL, 16'h0002);    // power-down, adapt off
        read_and_compare(`DFE_OFF_CTRL, 16'h0002);
        report_test("control", base_err);
    endtask

    task automatic raw_passthrough();
        int base_err;
        base_err = errors;
        write_and_compare(`DFE_OFF_DFE12, 16'h1234);
        read_and_compare(`DFE_OFF_DFE12, 16'h1234);
        write_and_compare(`DFE_OFF_DFE13, 16'hc3a5);
        read_and_compare(`DFE_OFF_DFE13, 16'hc3a5);
        report_test("raw dfe12 and dfe13", base_err);
    endtask

    task automatic illegal_offset();
        int          base_err;
        int unsigned base_go;
        logic [15:0] rd;
        base_err = errors;
        base_go  = i_phy.go_count;
        @(posedge clk);
        uif_mode  <= `DFE_MODE_WR;
        uif_addr  <= 6'd5;
        uif_wdata <= 16'hffff;
        uif_go    <= 1'b1;
        @(posedge clk);
        uif_go    <= 1'b0;
        @(negedge clk);
        check("addr_err on offset 5", {15'b0, uif_addr_err}, 16'd1);
        check("busy on offset 5", {15'b0, uif_busy}, 16'd0);
        repeat (10) @(negedge clk);   // window for a stray ctrl_go
        check("busy later", {15'b0, uif_busy}, 16'd0);
        check("go count on offset 5", 16'(i_phy.go_count - base_go), 16'd0);
        run_access(`DFE_MODE_RD, `DFE_OFF_TAP1, 16'h0000, rd);
        check("addr_err after legal", {15'b0, uif_addr_err}, 16'd0);
        report_test("illegal offset", base_err);
    endtask

    task automatic chan_err_abort();
        int          base_err;
        int unsigned base_go;
        logic [15:0] old11;
        logic [15:0] rd;
        base_err = errors;
        base_go  = i_phy.go_count;
        old11    = i_phy.regs[`DFE_PHY_DFE11];
        @(posedge clk);
        err_inject <= 1'b1;
        run_access(`DFE_MODE_WR, `DFE_OFF_TAP2, 16'h0007, rd);
        check("go count on abort", 16'(i_phy.go_count - base_go), 16'd1);
        check("dfe11 on abort", i_phy.regs[`DFE_PHY_DFE11], old11);
        @(posedge clk);
        err_inject <= 1'b0;
        write_and_compare(`DFE_OFF_TAP2, 16'h0007);
        read_and_compare(`DFE_OFF_TAP2, 16'h0007);
        report_test("channel error", base_err);
    endtask

    initial begin
        reset      = 1'b1;
        uif_go     = 1'b0;
        uif_mode   = `DFE_MODE_RD;
        uif_addr   = '0;
        uif_wdata  = '0;
        err_inject = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("busy after reset", {15'b0, uif_busy}, 16'd0);
        check("addr_err after reset", {15'b0, uif_addr_err}, 16'd0);
        check("ctrl_go after reset", {15'b0, ctrl_go}, 16'd0);
        check("ctrl_lock after reset", {15'b0, ctrl_lock}, 16'd0);
        check("ctrl_opcode after reset", {13'b0, ctrl_opcode}, {13'b0, `DFE_OP_RD});
        tap1_access();
        tap2_step_access();
        ctrl_write_order();
        raw_passthrough();
        illegal_offset();
        chan_err_abort();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dfe_reg.f ====
+incdir+rtl
rtl/dfe_reg_pkg.sv
rtl/dfe_access_fsm.sv
rtl/dfe_field_map.sv
rtl/dfe_rdata_collect.sv
rtl/dfe_reg_top.sv
testbench/phy_reg_model.sv
testbench/tb_dfe_reg.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds tb_dfe_reg with Verilator, runs it and looks for the pass line in its output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_dfe_reg -Mdir obj_dir -f dfe_reg.f \
    || { echo "build failed"; exit 1; }

./obj_dir/Vtb_dfe_reg | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
